//--- hdl/isaPkg.sv
//##############################
// isaPkg
// instruction set encodings of the integer
// core and the COP0 exception cause codes
//##############################
package isaPkg;

	typedef logic [31:0] instr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;
	typedef logic [4:0] rtField_t;
	typedef logic [4:0] fmtField_t;
	typedef logic [4:0] excCode_t;

	localparam int INT_LINES = 8;

	// opcodes
	localparam opcode_t OPC_RFMT = 6'h00;
	localparam opcode_t OPC_REGIMM = 6'h01; // bgez/bltz group, rt selects
	localparam opcode_t OPC_J = 6'h02;
	localparam opcode_t OPC_JAL = 6'h03;
	localparam opcode_t OPC_BEQ = 6'h04;
	localparam opcode_t OPC_BNE = 6'h05;
	localparam opcode_t OPC_BLEZ = 6'h06;
	localparam opcode_t OPC_BGTZ = 6'h07;
	localparam opcode_t OPC_ADDI = 6'h08;
	localparam opcode_t OPC_ADDIU = 6'h09;
	localparam opcode_t OPC_SLTI = 6'h0a;
	localparam opcode_t OPC_SLTIU = 6'h0b;
	localparam opcode_t OPC_ANDI = 6'h0c;
	localparam opcode_t OPC_ORI = 6'h0d;
	localparam opcode_t OPC_XORI = 6'h0e;
	localparam opcode_t OPC_LUI = 6'h0f;
	localparam opcode_t OPC_COP0 = 6'h10;
	localparam opcode_t OPC_LB = 6'h20;
	localparam opcode_t OPC_LH = 6'h21;
	localparam opcode_t OPC_LW = 6'h23;
	localparam opcode_t OPC_LBU = 6'h24;
	localparam opcode_t OPC_LHU = 6'h25;
	localparam opcode_t OPC_SB = 6'h28;
	localparam opcode_t OPC_SH = 6'h29;
	localparam opcode_t OPC_SW = 6'h2b;

	// R-type functions
	localparam funct_t FUN_SLL = 6'h00;
	localparam funct_t FUN_SRL = 6'h02;
	localparam funct_t FUN_SRA = 6'h03;
	localparam funct_t FUN_SLLV = 6'h04;
	localparam funct_t FUN_SRLV = 6'h06;
	localparam funct_t FUN_SRAV = 6'h07;
	localparam funct_t FUN_JR = 6'h08;
	localparam funct_t FUN_SYSCALL = 6'h0c;
	localparam funct_t FUN_MFHI = 6'h10;
	localparam funct_t FUN_MTHI = 6'h11;
	localparam funct_t FUN_MFLO = 6'h12;
	localparam funct_t FUN_MTLO = 6'h13;
	localparam funct_t FUN_MULT = 6'h18;
	localparam funct_t FUN_MULTU = 6'h19;
	localparam funct_t FUN_DIV = 6'h1a;
	localparam funct_t FUN_DIVU = 6'h1b;
	localparam funct_t FUN_ADD = 6'h20; // traps on overflow
	localparam funct_t FUN_ADDU = 6'h21;
	localparam funct_t FUN_SUB = 6'h22; // traps on overflow
	localparam funct_t FUN_SUBU = 6'h23;
	localparam funct_t FUN_AND = 6'h24;
	localparam funct_t FUN_OR = 6'h25;
	localparam funct_t FUN_XOR = 6'h26;
	localparam funct_t FUN_NOR = 6'h27;
	localparam funct_t FUN_SLT = 6'h2a;
	localparam funct_t FUN_SLTU = 6'h2b;

	// REGIMM rt codes, bit 0 is the ge/lt select and bit 4 the link
	localparam rtField_t RT_BLTZ = 5'h00;
	localparam rtField_t RT_BGEZ = 5'h01;
	localparam rtField_t RT_BLTZAL = 5'h10;
	localparam rtField_t RT_BGEZAL = 5'h11;

	// COP0 formats
	localparam fmtField_t FMT_MFC = 5'h00;
	localparam fmtField_t FMT_MTC = 5'h04;
	localparam fmtField_t FMT_ERET = 5'h10; // CO bit set
	localparam funct_t FUN_ERET = 6'h18;

	// cause codes
	localparam excCode_t EXC_INT = 5'd0;
	localparam excCode_t EXC_SYS = 5'd8;
	localparam excCode_t EXC_INSTR = 5'd10;
	localparam excCode_t EXC_ALU = 5'd12;

endpackage

//--- hdl/ctrlPkg.sv
//##############################
// ctrlPkg
// datapath control field types and the
// control word structs of the control unit
//##############################
package ctrlPkg;

	typedef logic [1:0] regDst_t;
	localparam regDst_t RD_RT = 2'd0;
	localparam regDst_t RD_RD = 2'd1;
	localparam regDst_t RD_RA = 2'd2; // link register

	typedef logic [1:0] aluSrc_t;
	localparam aluSrc_t SRC_REG = 2'd0;
	localparam aluSrc_t SRC_SIMM = 2'd1;
	localparam aluSrc_t SRC_ZIMM = 2'd2;
	localparam aluSrc_t SRC_ZERO = 2'd3; // compare against zero

	typedef logic [2:0] wbSel_t;
	localparam wbSel_t WB_ALU = 3'd0;
	localparam wbSel_t WB_PC4 = 3'd2;
	localparam wbSel_t WB_UPPER = 3'd3;
	localparam wbSel_t WB_COP0 = 3'd5;
	localparam wbSel_t WB_MEM = 3'd6;

	typedef logic [2:0] pcSel_t;
	localparam pcSel_t PC_SEQ = 3'd0;
	localparam pcSel_t PC_BRZ = 3'd1; // taken when alu result is zero
	localparam pcSel_t PC_JUMP = 3'd2;
	localparam pcSel_t PC_REG = 3'd3;
	localparam pcSel_t PC_EXC = 3'd4;
	localparam pcSel_t PC_BRNZ = 3'd5;

	typedef logic [1:0] aluOp_t;
	localparam aluOp_t ALU_ADD = 2'd0;
	localparam aluOp_t ALU_SUB = 2'd1;
	localparam aluOp_t ALU_FUNCT = 2'd2;
	localparam aluOp_t ALU_IMM = 2'd3;

	typedef logic [2:0] excClass_t;
	localparam excClass_t EC_NONE = 3'd0;
	localparam excClass_t EC_OVF = 3'd1;
	localparam excClass_t EC_SYS = 3'd2;
	localparam excClass_t EC_RESV = 3'd3;
	localparam excClass_t EC_MFC0 = 3'd4;
	localparam excClass_t EC_MTC0 = 3'd5;
	localparam excClass_t EC_ERET = 3'd6;

	typedef struct packed {
		regDst_t regDst;
		aluSrc_t aluSrc;
		wbSel_t wbSel;
		logic regWrite;
		logic memRead;
		logic memWrite;
		pcSel_t pcSel;
		aluOp_t aluOp;
		logic branchDelay;
	} dpCtrl_t;

	typedef struct packed {
		logic cop0Write;
		logic eret;
		logic excOccurred;
		isaPkg::excCode_t excCode;
	} cop0Ctrl_t;

endpackage

//--- hdl/mainDecoder.sv
//##############################
// mainDecoder
// combinational decode of an instruction word
// into datapath controls and an exception class
//##############################
`timescale 1ns/100ps

module mainDecoder (
	input isaPkg::instr_t instr,
	output ctrlPkg::dpCtrl_t dpCtrl,
	output ctrlPkg::excClass_t excClass
);

	isaPkg::opcode_t opcode;
	isaPkg::funct_t funct;
	isaPkg::rtField_t rt;
	isaPkg::fmtField_t fmt;

	assign opcode = instr[31:26];
	assign fmt = instr[25:21]; // rs slot, used by COP0
	assign rt = instr[20:16];
	assign funct = instr[5:0];

	always_comb
	begin
		dpCtrl = '0;
		excClass = ctrlPkg::EC_NONE;
		case (opcode)
			isaPkg::OPC_SW,
			isaPkg::OPC_SH,
			isaPkg::OPC_SB:
			begin
				dpCtrl.aluSrc = ctrlPkg::SRC_SIMM;
				dpCtrl.memWrite = 1'b1;
			end

			isaPkg::OPC_LW,
			isaPkg::OPC_LH,
			isaPkg::OPC_LHU,
			isaPkg::OPC_LB,
			isaPkg::OPC_LBU:
			begin
				dpCtrl.aluSrc = ctrlPkg::SRC_SIMM;
				dpCtrl.wbSel = ctrlPkg::WB_MEM;
				dpCtrl.regWrite = 1'b1;
				dpCtrl.memRead = 1'b1;
			end

			isaPkg::OPC_BEQ,
			isaPkg::OPC_BNE:
			begin
				dpCtrl.pcSel = (opcode == isaPkg::OPC_BEQ) ? ctrlPkg::PC_BRZ : ctrlPkg::PC_BRNZ;
				dpCtrl.aluOp = ctrlPkg::ALU_SUB;
				dpCtrl.branchDelay = 1'b1;
			end

			isaPkg::OPC_RFMT:
			begin
				case (funct)
					isaPkg::FUN_JR:
					begin
						dpCtrl.pcSel = ctrlPkg::PC_REG;
						dpCtrl.branchDelay = 1'b1;
					end

					isaPkg::FUN_SYSCALL:
					begin
						dpCtrl.pcSel = ctrlPkg::PC_EXC;
						excClass = ctrlPkg::EC_SYS;
					end

					isaPkg::FUN_ADD, isaPkg::FUN_SUB,
					isaPkg::FUN_ADDU, isaPkg::FUN_SUBU,
					isaPkg::FUN_AND, isaPkg::FUN_OR, isaPkg::FUN_XOR, isaPkg::FUN_NOR,
					isaPkg::FUN_SLT, isaPkg::FUN_SLTU,
					isaPkg::FUN_SLL, isaPkg::FUN_SRL, isaPkg::FUN_SRA,
					isaPkg::FUN_SLLV, isaPkg::FUN_SRLV, isaPkg::FUN_SRAV,
					isaPkg::FUN_MFHI, isaPkg::FUN_MTHI, isaPkg::FUN_MFLO, isaPkg::FUN_MTLO,
					isaPkg::FUN_MULT, isaPkg::FUN_MULTU, isaPkg::FUN_DIV, isaPkg::FUN_DIVU:
					begin
						dpCtrl.regDst = ctrlPkg::RD_RD;
						dpCtrl.regWrite = 1'b1;
						dpCtrl.aluOp = ctrlPkg::ALU_FUNCT;
						if (funct == isaPkg::FUN_ADD || funct == isaPkg::FUN_SUB)
						begin
							excClass = ctrlPkg::EC_OVF;
						end
					end

					default:
					begin
						excClass = ctrlPkg::EC_RESV;
					end
				endcase
			end

			isaPkg::OPC_J:
			begin
				dpCtrl.regDst = ctrlPkg::RD_RD;
				dpCtrl.pcSel = ctrlPkg::PC_JUMP;
				dpCtrl.branchDelay = 1'b1;
			end

			isaPkg::OPC_JAL:
			begin
				dpCtrl.regDst = ctrlPkg::RD_RA;
				dpCtrl.wbSel = ctrlPkg::WB_PC4;
				dpCtrl.regWrite = 1'b1;
				dpCtrl.pcSel = ctrlPkg::PC_JUMP;
				dpCtrl.branchDelay = 1'b1;
			end

			isaPkg::OPC_ADDI,
			isaPkg::OPC_ADDIU,
			isaPkg::OPC_SLTI,
			isaPkg::OPC_SLTIU:
			begin
				dpCtrl.aluSrc = ctrlPkg::SRC_SIMM;
				dpCtrl.regWrite = 1'b1;
				dpCtrl.aluOp = ctrlPkg::ALU_IMM;
				if (opcode == isaPkg::OPC_ADDI)
				begin
					excClass = ctrlPkg::EC_OVF;
				end
			end

			isaPkg::OPC_ANDI,
			isaPkg::OPC_ORI,
			isaPkg::OPC_XORI:
			begin
				dpCtrl.aluSrc = ctrlPkg::SRC_ZIMM;
				dpCtrl.regWrite = 1'b1;
				dpCtrl.aluOp = ctrlPkg::ALU_IMM;
			end

			isaPkg::OPC_LUI:
			begin
				dpCtrl.wbSel = ctrlPkg::WB_UPPER;
				dpCtrl.regWrite = 1'b1;
			end

			isaPkg::OPC_BLEZ,
			isaPkg::OPC_BGTZ:
			begin
				dpCtrl.aluSrc = ctrlPkg::SRC_ZERO;
				dpCtrl.aluOp = ctrlPkg::ALU_IMM;
				dpCtrl.pcSel = (opcode == isaPkg::OPC_BLEZ) ? ctrlPkg::PC_BRZ : ctrlPkg::PC_BRNZ;
				dpCtrl.branchDelay = 1'b1;
			end

			isaPkg::OPC_REGIMM:
			begin
				case (rt)
					isaPkg::RT_BGEZ,
					isaPkg::RT_BLTZ,
					isaPkg::RT_BGEZAL,
					isaPkg::RT_BLTZAL:
					begin
						dpCtrl.aluSrc = ctrlPkg::SRC_ZERO;
						dpCtrl.aluOp = ctrlPkg::ALU_IMM;
						dpCtrl.pcSel = rt[0] ? ctrlPkg::PC_BRZ : ctrlPkg::PC_BRNZ; // ge vs lt
						dpCtrl.branchDelay = 1'b1;
						if (rt[4]) // link variants
						begin
							dpCtrl.regDst = ctrlPkg::RD_RA;
							dpCtrl.wbSel = ctrlPkg::WB_PC4;
							dpCtrl.regWrite = 1'b1;
						end
					end

					default:
					begin
						excClass = ctrlPkg::EC_RESV;
					end
				endcase
			end

			isaPkg::OPC_COP0:
			begin
				case (fmt)
					isaPkg::FMT_MFC:
					begin
						dpCtrl.wbSel = ctrlPkg::WB_COP0;
						dpCtrl.regWrite = 1'b1;
						excClass = ctrlPkg::EC_MFC0;
					end

					isaPkg::FMT_MTC:
					begin
						excClass = ctrlPkg::EC_MTC0; // write enable comes from resolver
					end

					isaPkg::FMT_ERET:
					begin
						if (funct == isaPkg::FUN_ERET)
						begin
							dpCtrl.pcSel = ctrlPkg::PC_EXC;
							excClass = ctrlPkg::EC_ERET;
						end
						else
						begin
							excClass = ctrlPkg::EC_RESV;
						end
					end

					default:
					begin
						excClass = ctrlPkg::EC_RESV;
					end
				endcase
			end

			default:
			begin
				excClass = ctrlPkg::EC_RESV;
			end
		endcase
	end

endmodule

//--- hdl/excResolver.sv
//##############################
// excResolver
// resolves interrupts, traps and COP0 privilege,
// then registers the full control word
//##############################
`timescale 1ns/100ps

module excResolver (
	input logic iCLK,
	input logic arstN,
	input ctrlPkg::dpCtrl_t dpCtrl,
	input ctrlPkg::excClass_t excClass,
	input logic aluOverflow,
	input logic excLevel,
	input logic userMode,
	input logic [isaPkg::INT_LINES-1:0] pendingInt,
	output ctrlPkg::dpCtrl_t dpOut,
	output ctrlPkg::cop0Ctrl_t cop0Out
);

	logic anyPending;
	logic intReq;
	ctrlPkg::cop0Ctrl_t cop0Next;

	assign anyPending = |pendingInt;
	assign intReq = anyPending && !excLevel; // masked inside a handler

	always_comb
	begin
		cop0Next = '0;
		case (excClass)
			ctrlPkg::EC_NONE:
			begin
				cop0Next.excOccurred = intReq;
				cop0Next.excCode = isaPkg::EXC_INT;
			end

			ctrlPkg::EC_OVF:
			begin
				cop0Next.excOccurred = (aluOverflow || anyPending) && !excLevel;
				cop0Next.excCode = aluOverflow ? isaPkg::EXC_ALU : isaPkg::EXC_INT;
			end

			ctrlPkg::EC_SYS:
			begin
				cop0Next.excOccurred = !excLevel;
				cop0Next.excCode = isaPkg::EXC_SYS;
			end

			ctrlPkg::EC_MFC0:
			begin
				cop0Next.excOccurred = userMode; // privileged
				cop0Next.excCode = isaPkg::EXC_INSTR;
			end

			ctrlPkg::EC_MTC0:
			begin
				cop0Next.cop0Write = !userMode;
				cop0Next.excOccurred = userMode;
				cop0Next.excCode = isaPkg::EXC_INSTR;
			end

			ctrlPkg::EC_ERET:
			begin
				cop0Next.eret = !userMode;
				cop0Next.excOccurred = userMode;
				cop0Next.excCode = isaPkg::EXC_INSTR;
			end

			default: // EC_RESV
			begin
				cop0Next.excOccurred = !excLevel;
				cop0Next.excCode = isaPkg::EXC_INSTR;
			end
		endcase
	end

	// decode to execute boundary
	always_ff @(posedge iCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			dpOut <= '0;
			cop0Out <= '0;
		end
		else
		begin
			dpOut <= dpCtrl;
			cop0Out <= cop0Next;
		end
	end

endmodule

//--- hdl/controlUnit.sv
//##############################
// controlUnit
// single cycle control, decoder feeding the
// exception resolver, one cycle latency
//##############################
`timescale 1ns/100ps

module controlUnit (
	input logic iCLK,
	input logic arstN,
	input isaPkg::instr_t instr,
	input logic aluOverflow,
	input logic excLevel,
	input logic userMode,
	input logic [isaPkg::INT_LINES-1:0] pendingInt,
	output ctrlPkg::dpCtrl_t dpOut,
	output ctrlPkg::cop0Ctrl_t cop0Out
);

	ctrlPkg::dpCtrl_t dpCtrl;
	ctrlPkg::excClass_t excClass;

	mainDecoder uDecoder (
		.instr(instr),
		.dpCtrl(dpCtrl),
		.excClass(excClass)
	);

	excResolver uResolver (
		.iCLK(iCLK),
		.arstN(arstN),
		.dpCtrl(dpCtrl),
		.excClass(excClass),
		.aluOverflow(aluOverflow),
		.excLevel(excLevel),
		.userMode(userMode),
		.pendingInt(pendingInt),
		.dpOut(dpOut),
		.cop0Out(cop0Out)
	);

endmodule

//--- verif/control_asserts.sv
//##############################
// control_asserts
// concurrent checks on the control unit outputs
//##############################
`timescale 1ns/100ps

module control_asserts (
	input logic iCLK,
	input logic arstN,
	input logic userMode,
	input ctrlPkg::dpCtrl_t dpOut,
	input ctrlPkg::cop0Ctrl_t cop0Out
);

	int failCount = 0;

	// cop0 side effects are privileged
	privCheck: assert property (@(posedge iCLK) disable iff (!arstN)
		$past(userMode) |-> !(cop0Out.eret || cop0Out.cop0Write))
	else
	begin
		failCount++;
		$error("eret or cop0Write raised for a user mode instruction");
	end

	memCheck: assert property (@(posedge iCLK) disable iff (!arstN)
		!(dpOut.memRead && dpOut.memWrite))
	else
	begin
		failCount++;
		$error("memRead and memWrite high together");
	end

	resetCheck: assert property (@(posedge iCLK)
		!arstN |=> (dpOut == '0) && (cop0Out == '0))
	else
	begin
		failCount++;
		$error("outputs not cleared after reset");
	end

endmodule

bind controlUnit control_asserts uAsserts (
	.iCLK(iCLK),
	.arstN(arstN),
	.userMode(userMode),
	.dpOut(dpOut),
	.cop0Out(cop0Out)
);

//--- verif/ctrlChecker.sv
//##############################
// ctrlChecker
// reference model of decode and exception
// resolution, compares the registered outputs
//##############################
`timescale 1ns/100ps

module ctrlChecker (
	input logic iCLK,
	input logic arstN,
	input isaPkg::instr_t instr,
	input logic aluOverflow,
	input logic excLevel,
	input logic userMode,
	input logic [isaPkg::INT_LINES-1:0] pendingInt,
	input ctrlPkg::dpCtrl_t dpOut,
	input ctrlPkg::cop0Ctrl_t cop0Out,
	output int errCount,
	output int checkCount
);

	ctrlPkg::dpCtrl_t dpExp = '0;
	ctrlPkg::cop0Ctrl_t cop0Exp = '0;
	int errors = 0;
	int checks = 0;

	assign errCount = errors;
	assign checkCount = checks;

	function automatic logic isAluFunct(input isaPkg::funct_t f);
		case (f)
			isaPkg::FUN_SLL, isaPkg::FUN_SRL, isaPkg::FUN_SRA, isaPkg::FUN_SLLV,
			isaPkg::FUN_SRLV, isaPkg::FUN_SRAV, isaPkg::FUN_MFHI, isaPkg::FUN_MTHI,
			isaPkg::FUN_MFLO, isaPkg::FUN_MTLO, isaPkg::FUN_MULT, isaPkg::FUN_MULTU,
			isaPkg::FUN_DIV, isaPkg::FUN_DIVU, isaPkg::FUN_ADD, isaPkg::FUN_ADDU,
			isaPkg::FUN_SUB, isaPkg::FUN_SUBU, isaPkg::FUN_AND, isaPkg::FUN_OR,
			isaPkg::FUN_XOR, isaPkg::FUN_NOR, isaPkg::FUN_SLT, isaPkg::FUN_SLTU: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic ctrlPkg::dpCtrl_t zeroBranch(input ctrlPkg::pcSel_t sel);
		ctrlPkg::dpCtrl_t d;
		d = '0;
		d.aluSrc = ctrlPkg::SRC_ZERO;
		d.aluOp = ctrlPkg::ALU_IMM;
		d.pcSel = sel;
		d.branchDelay = 1'b1;
		return d;
	endfunction

	function automatic ctrlPkg::excClass_t decode(input isaPkg::instr_t w,
			output ctrlPkg::dpCtrl_t d);
		isaPkg::opcode_t op;
		isaPkg::funct_t fn;
		isaPkg::rtField_t rt;
		isaPkg::fmtField_t fmt;
		ctrlPkg::excClass_t cls;
		op = w[31:26];
		fmt = w[25:21];
		rt = w[20:16];
		fn = w[5:0];
		d = '0;
		cls = ctrlPkg::EC_NONE;
		case (op)
			isaPkg::OPC_SB, isaPkg::OPC_SH, isaPkg::OPC_SW:
			begin
				d.aluSrc = ctrlPkg::SRC_SIMM;
				d.memWrite = 1'b1;
			end
			isaPkg::OPC_LB, isaPkg::OPC_LH, isaPkg::OPC_LW, isaPkg::OPC_LBU, isaPkg::OPC_LHU:
			begin
				d.aluSrc = ctrlPkg::SRC_SIMM;
				d.wbSel = ctrlPkg::WB_MEM;
				d.regWrite = 1'b1;
				d.memRead = 1'b1;
			end
			isaPkg::OPC_BEQ:
			begin
				d.pcSel = ctrlPkg::PC_BRZ;
				d.aluOp = ctrlPkg::ALU_SUB;
				d.branchDelay = 1'b1;
			end
			isaPkg::OPC_BNE:
			begin
				d.pcSel = ctrlPkg::PC_BRNZ;
				d.aluOp = ctrlPkg::ALU_SUB;
				d.branchDelay = 1'b1;
			end
			isaPkg::OPC_RFMT:
			begin
				if (fn == isaPkg::FUN_JR)
				begin
					d.pcSel = ctrlPkg::PC_REG;
					d.branchDelay = 1'b1;
				end
				else if (fn == isaPkg::FUN_SYSCALL)
				begin
					d.pcSel = ctrlPkg::PC_EXC;
					cls = ctrlPkg::EC_SYS;
				end
				else if (isAluFunct(fn))
				begin
					d.regDst = ctrlPkg::RD_RD;
					d.regWrite = 1'b1;
					d.aluOp = ctrlPkg::ALU_FUNCT;
					if (fn == isaPkg::FUN_ADD || fn == isaPkg::FUN_SUB)
					begin
						cls = ctrlPkg::EC_OVF;
					end
				end
				else
				begin
					cls = ctrlPkg::EC_RESV;
				end
			end
			isaPkg::OPC_J:
			begin
				d.regDst = ctrlPkg::RD_RD;
				d.pcSel = ctrlPkg::PC_JUMP;
				d.branchDelay = 1'b1;
			end
			isaPkg::OPC_JAL:
			begin
				d.regDst = ctrlPkg::RD_RA;
				d.wbSel = ctrlPkg::WB_PC4;
				d.regWrite = 1'b1;
				d.pcSel = ctrlPkg::PC_JUMP;
				d.branchDelay = 1'b1;
			end
			isaPkg::OPC_ADDI, isaPkg::OPC_ADDIU, isaPkg::OPC_SLTI, isaPkg::OPC_SLTIU:
			begin
				d.aluSrc = ctrlPkg::SRC_SIMM;
				d.regWrite = 1'b1;
				d.aluOp = ctrlPkg::ALU_IMM;
				cls = (op == isaPkg::OPC_ADDI) ? ctrlPkg::EC_OVF : ctrlPkg::EC_NONE;
			end
			isaPkg::OPC_ANDI, isaPkg::OPC_ORI, isaPkg::OPC_XORI:
			begin
				d.aluSrc = ctrlPkg::SRC_ZIMM;
				d.regWrite = 1'b1;
				d.aluOp = ctrlPkg::ALU_IMM;
			end
			isaPkg::OPC_LUI:
			begin
				d.wbSel = ctrlPkg::WB_UPPER;
				d.regWrite = 1'b1;
			end
			isaPkg::OPC_BLEZ: d = zeroBranch(ctrlPkg::PC_BRZ);
			isaPkg::OPC_BGTZ: d = zeroBranch(ctrlPkg::PC_BRNZ);
			isaPkg::OPC_REGIMM:
			begin
				if (rt == isaPkg::RT_BGEZ || rt == isaPkg::RT_BGEZAL)
				begin
					d = zeroBranch(ctrlPkg::PC_BRZ);
				end
				else if (rt == isaPkg::RT_BLTZ || rt == isaPkg::RT_BLTZAL)
				begin
					d = zeroBranch(ctrlPkg::PC_BRNZ);
				end
				else
				begin
					cls = ctrlPkg::EC_RESV;
				end
				if (rt == isaPkg::RT_BGEZAL || rt == isaPkg::RT_BLTZAL)
				begin
					d.regDst = ctrlPkg::RD_RA;
					d.wbSel = ctrlPkg::WB_PC4;
					d.regWrite = 1'b1;
				end
			end
			isaPkg::OPC_COP0:
			begin
				if (fmt == isaPkg::FMT_MFC)
				begin
					d.wbSel = ctrlPkg::WB_COP0;
					d.regWrite = 1'b1;
					cls = ctrlPkg::EC_MFC0;
				end
				else if (fmt == isaPkg::FMT_MTC)
				begin
					cls = ctrlPkg::EC_MTC0;
				end
				else if (fmt == isaPkg::FMT_ERET && fn == isaPkg::FUN_ERET)
				begin
					d.pcSel = ctrlPkg::PC_EXC;
					cls = ctrlPkg::EC_ERET;
				end
				else
				begin
					cls = ctrlPkg::EC_RESV;
				end
			end
			default: cls = ctrlPkg::EC_RESV;
		endcase
		return cls;
	endfunction

	function automatic ctrlPkg::cop0Ctrl_t resolve(input ctrlPkg::excClass_t cls);
		ctrlPkg::cop0Ctrl_t c;
		logic pend;
		pend = |pendingInt;
		c = '0;
		c.excCode = isaPkg::EXC_INSTR; // privileged and reserved cases
		case (cls)
			ctrlPkg::EC_NONE:
			begin
				c.excOccurred = pend && !excLevel;
				c.excCode = isaPkg::EXC_INT;
			end
			ctrlPkg::EC_OVF:
			begin
				c.excOccurred = (aluOverflow || pend) && !excLevel;
				c.excCode = aluOverflow ? isaPkg::EXC_ALU : isaPkg::EXC_INT;
			end
			ctrlPkg::EC_SYS:
			begin
				c.excOccurred = !excLevel;
				c.excCode = isaPkg::EXC_SYS;
			end
			ctrlPkg::EC_RESV: c.excOccurred = !excLevel;
			default:
			begin
				c.excOccurred = userMode;
				c.cop0Write = (cls == ctrlPkg::EC_MTC0) && !userMode;
				c.eret = (cls == ctrlPkg::EC_ERET) && !userMode;
			end
		endcase
		return c;
	endfunction

	task automatic compareField(input string name, input logic [7:0] expVal,
			input logic [7:0] actVal);
		checks++;
		if (expVal !== actVal)
		begin
			errors++;
			$display("Error: %s expected %h actual %h at %0t", name, expVal, actVal, $time);
		end
	endtask

	// outputs are stable mid cycle
	always @(negedge iCLK)
	begin
		compareField("dpOut.regDst", 8'(dpExp.regDst), 8'(dpOut.regDst));
		compareField("dpOut.aluSrc", 8'(dpExp.aluSrc), 8'(dpOut.aluSrc));
		compareField("dpOut.wbSel", 8'(dpExp.wbSel), 8'(dpOut.wbSel));
		compareField("dpOut.regWrite", 8'(dpExp.regWrite), 8'(dpOut.regWrite));
		compareField("dpOut.memRead", 8'(dpExp.memRead), 8'(dpOut.memRead));
		compareField("dpOut.memWrite", 8'(dpExp.memWrite), 8'(dpOut.memWrite));
		compareField("dpOut.pcSel", 8'(dpExp.pcSel), 8'(dpOut.pcSel));
		compareField("dpOut.aluOp", 8'(dpExp.aluOp), 8'(dpOut.aluOp));
		compareField("dpOut.branchDelay", 8'(dpExp.branchDelay), 8'(dpOut.branchDelay));
		compareField("cop0Out.cop0Write", 8'(cop0Exp.cop0Write), 8'(cop0Out.cop0Write));
		compareField("cop0Out.eret", 8'(cop0Exp.eret), 8'(cop0Out.eret));
		compareField("cop0Out.excOccurred", 8'(cop0Exp.excOccurred), 8'(cop0Out.excOccurred));
		compareField("cop0Out.excCode", 8'(cop0Exp.excCode), 8'(cop0Out.excCode));
		if (!arstN)
		begin
			dpExp = '0; // held in reset at next edge
			cop0Exp = '0;
		end
		else
		begin
			cop0Exp = resolve(decode(instr, dpExp));
		end
	end

endmodule

//--- verif/tb.sv
//##############################
// tb
// drives the control unit with seeded random
// instructions, runs watchdog and final report
//##############################
`timescale 1ns/100ps

module tb;

	localparam int NUM_CYCLES = 2000;
	localparam int CLK_PERIOD = 4;
	localparam int NUM_OPC = 25;
	localparam int NUM_FUNCT = 26;

	logic iCLK = 1'b0;
	logic arstN;
	isaPkg::instr_t instr;
	logic aluOverflow;
	logic excLevel;
	logic userMode;
	logic [isaPkg::INT_LINES-1:0] pendingInt;
	ctrlPkg::dpCtrl_t dpOut;
	ctrlPkg::cop0Ctrl_t cop0Out;
	int errCount;
	int checkCount;
	int seed;

	isaPkg::opcode_t opcodes [NUM_OPC] = '{
		isaPkg::OPC_RFMT, isaPkg::OPC_REGIMM, isaPkg::OPC_J, isaPkg::OPC_JAL,
		isaPkg::OPC_BEQ, isaPkg::OPC_BNE, isaPkg::OPC_BLEZ, isaPkg::OPC_BGTZ,
		isaPkg::OPC_ADDI, isaPkg::OPC_ADDIU, isaPkg::OPC_SLTI, isaPkg::OPC_SLTIU,
		isaPkg::OPC_ANDI, isaPkg::OPC_ORI, isaPkg::OPC_XORI, isaPkg::OPC_LUI,
		isaPkg::OPC_COP0, isaPkg::OPC_LB, isaPkg::OPC_LH, isaPkg::OPC_LW,
		isaPkg::OPC_LBU, isaPkg::OPC_LHU, isaPkg::OPC_SB, isaPkg::OPC_SH,
		isaPkg::OPC_SW
	};
	isaPkg::funct_t functs [NUM_FUNCT] = '{
		isaPkg::FUN_SLL, isaPkg::FUN_SRL, isaPkg::FUN_SRA, isaPkg::FUN_SLLV,
		isaPkg::FUN_SRLV, isaPkg::FUN_SRAV, isaPkg::FUN_JR, isaPkg::FUN_SYSCALL,
		isaPkg::FUN_MFHI, isaPkg::FUN_MTHI, isaPkg::FUN_MFLO, isaPkg::FUN_MTLO,
		isaPkg::FUN_MULT, isaPkg::FUN_MULTU, isaPkg::FUN_DIV, isaPkg::FUN_DIVU,
		isaPkg::FUN_ADD, isaPkg::FUN_ADDU, isaPkg::FUN_SUB, isaPkg::FUN_SUBU,
		isaPkg::FUN_AND, isaPkg::FUN_OR, isaPkg::FUN_XOR, isaPkg::FUN_NOR,
		isaPkg::FUN_SLT, isaPkg::FUN_SLTU
	};
	isaPkg::rtField_t rtCodes [4] = '{
		isaPkg::RT_BGEZ, isaPkg::RT_BGEZAL, isaPkg::RT_BLTZ, isaPkg::RT_BLTZAL
	};
	isaPkg::fmtField_t fmtCodes [3] = '{isaPkg::FMT_MFC, isaPkg::FMT_MTC, isaPkg::FMT_ERET};

	controlUnit DUT (
		.iCLK(iCLK),
		.arstN(arstN),
		.instr(instr),
		.aluOverflow(aluOverflow),
		.excLevel(excLevel),
		.userMode(userMode),
		.pendingInt(pendingInt),
		.dpOut(dpOut),
		.cop0Out(cop0Out)
	);

	ctrlChecker uChecker (
		.iCLK(iCLK),
		.arstN(arstN),
		.instr(instr),
		.aluOverflow(aluOverflow),
		.excLevel(excLevel),
		.userMode(userMode),
		.pendingInt(pendingInt),
		.dpOut(dpOut),
		.cop0Out(cop0Out),
		.errCount(errCount),
		.checkCount(checkCount)
	);

	always #(CLK_PERIOD / 2) iCLK = ~iCLK;

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic driveInputs();
		isaPkg::instr_t w;
		logic [31:0] r;
		w = $random(seed);
		r = $random(seed);
		if (r[2:0] != 3'd0) // otherwise keep the fully random word
		begin
			w[31:26] = opcodes[randBelow(NUM_OPC)];
			case (w[31:26])
				isaPkg::OPC_RFMT: w[5:0] = functs[randBelow(NUM_FUNCT)];
				isaPkg::OPC_REGIMM: w[20:16] = rtCodes[randBelow(4)];
				isaPkg::OPC_COP0:
				begin
					w[25:21] = fmtCodes[randBelow(3)];
					if (randBelow(4) != 0)
					begin
						w[5:0] = isaPkg::FUN_ERET; // mostly a real eret
					end
				end
				default: ;
			endcase
		end
		instr = w;
		aluOverflow = (randBelow(2) == 1);
		excLevel = (randBelow(4) == 0);
		userMode = (randBelow(2) == 1);
		pendingInt = '0;
		if (randBelow(4) == 0)
		begin
			pendingInt = r[isaPkg::INT_LINES+7:8];
		end
	endtask

	initial
	begin
		seed = 32'he2ef5fa0;
		arstN = 1'b1;
		instr = '0;
		aluOverflow = 1'b0;
		excLevel = 1'b0;
		userMode = 1'b0;
		pendingInt = '0;
		#1 arstN = 1'b0;
		repeat (2) @(posedge iCLK);
		#0.5 arstN = 1'b1;
		for (int i = 0; i < NUM_CYCLES; i++)
		begin
			driveInputs();
			@(posedge iCLK);
			#0.5;
		end
		@(negedge iCLK); // last result compared here
		#0.5;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checkCount, errCount, DUT.uAsserts.failCount);
		if (errCount == 0 && DUT.uAsserts.failCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		#((NUM_CYCLES + 20) * CLK_PERIOD);
		$display("Timeout: the run did not end within %0d clock cycles", NUM_CYCLES + 20);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- tb.f
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/mainDecoder.sv
hdl/excResolver.sv
hdl/controlUnit.sv
verif/control_asserts.sv
verif/ctrlChecker.sv
verif/tb.sv

//--- run.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb -f tb.f -o Vtb

./obj_dir/Vtb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0
